/* fetch_sys.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/if_stage.sv
rtl/lsu_port.sv
rtl/bus_arbiter.sv
rtl/inst_mem.sv
rtl/fetch_sys_top.sv
dv/tb_fetch_sys.sv

/* run.sh */
#!/bin/sh
# compile and run the fetch system testbench with Verilator

set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_sys -f fetch_sys.f -o tb_fetch_sys

# the log decides the result, the simulator status alone does not
./obj_dir/tb_fetch_sys | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* dv/tb_fetch_sys.sv */
// testbench for the fetch system
// sequential fetch, redirects, decode back-pressure and load/store traffic
// checked against a memory mirror and a next-pc reference

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch_sys;
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);

  logic   clk;
  logic   rst;
  logic   refresh;
  logic   id_allowin;
  addr_t  bj_pc;
  logic   bj_ena;
  logic   bj_stall;
  logic   excp_jmp_ena;
  addr_t  excp_pc;
  logic   if_to_id_valid;
  word_t  if_inst;
  addr_t  if_pc;
  logic   data_req;
  logic   data_we;
  addr_t  data_addr;
  word_t  data_wdata;
  logic   data_busy;
  logic   data_done;
  word_t  data_rdata;

  // reference state
  word_t  mirror [`MEM_WORDS];
  addr_t  exp_pc;
  logic   pend_bj;
  logic   pend_excp;
  addr_t  pend_bj_pc;
  addr_t  pend_excp_pc;
  logic   hold_chk;
  addr_t  held_pc;
  word_t  held_inst;
  int     deliv_count;
  int     data_count;
  int     err_count;
  int     timeout_count;
  integer seed;

  fetch_sys_top uut (
    .clk            (clk),
    .rst            (rst),
    .refresh        (refresh),
    .id_allowin     (id_allowin),
    .bj_pc          (bj_pc),
    .bj_ena         (bj_ena),
    .bj_stall       (bj_stall),
    .excp_jmp_ena   (excp_jmp_ena),
    .excp_pc        (excp_pc),
    .if_to_id_valid (if_to_id_valid),
    .if_inst        (if_inst),
    .if_pc          (if_pc),
    .data_req       (data_req),
    .data_we        (data_we),
    .data_addr      (data_addr),
    .data_wdata     (data_wdata),
    .data_busy      (data_busy),
    .data_done      (data_done),
    .data_rdata     (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t expected_word(input addr_t addr);
    return mirror[addr[IDX_W+1:2]];
  endfunction

  // exception over branch/jump over the sequential step
  function automatic addr_t predict_pc(input logic excp_en, input addr_t excp_target,
                                       input logic bj_en, input addr_t bj_target,
                                       input addr_t cur_pc);
    if (excp_en) begin
      return excp_target;
    end
    if (bj_en) begin
      return bj_target;
    end
    return cur_pc + 32'd4;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s: got %08h, expected %08h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // words handed to decode, plus held outputs under back-pressure
  always @(posedge clk) begin
    if (!rst) begin
      if (hold_chk) begin
        check_value("if_pc held", if_pc, held_pc);
        check_value("if_inst held", if_inst, held_inst);
      end
      hold_chk  = if_to_id_valid && !id_allowin;
      held_pc   = if_pc;
      held_inst = if_inst;
      if (if_to_id_valid && id_allowin) begin
        check_value("if_pc", if_pc, exp_pc);
        check_value("if_inst", if_inst, expected_word(exp_pc));
        exp_pc    = predict_pc(pend_excp, pend_excp_pc, pend_bj, pend_bj_pc, exp_pc);
        pend_excp = 1'b0;
        pend_bj   = 1'b0;
        deliv_count++;
      end
    end
  end

  task automatic wait_deliveries(input int n);
    int target;
    int cycles;
    target = deliv_count + n;
    cycles = 0;
    while (deliv_count < target && cycles < n * 40) begin
      @(negedge clk);
      cycles++;
    end
    if (deliv_count < target) begin
      $display("timeout: fetch stage delivered %0d of %0d words",
               n - (target - deliv_count), n);
      timeout_count++;
    end
  endtask

  // park the sequencer in RETN with an empty stage, then redirect in one cycle
  task automatic redirect(input addr_t bj_target, input logic with_excp,
                          input addr_t excp_target);
    id_allowin = 1'b1;
    refresh    = 1'b0;
    bj_stall   = 1'b1;
    repeat (16) @(negedge clk);
    bj_stall     = 1'b0;
    bj_ena       = 1'b1;
    bj_pc        = bj_target;
    excp_jmp_ena = with_excp;
    excp_pc      = excp_target;
    // the parked word goes out first, the redirect applies after it
    pend_bj      = 1'b1;
    pend_bj_pc   = bj_target;
    pend_excp    = with_excp;
    pend_excp_pc = excp_target;
    @(negedge clk);
    bj_ena       = 1'b0;
    excp_jmp_ena = 1'b0;
  endtask

  task automatic random_backpressure(input int n);
    int target;
    int cycles;
    target = deliv_count + n;
    cycles = 0;
    while (deliv_count < target && cycles < n * 80) begin
      @(negedge clk);
      id_allowin = ($random(seed) & 3) != 0;
      refresh    = ($random(seed) & 7) == 0;
      bj_stall   = ($random(seed) & 7) < 2;
      cycles++;
    end
    id_allowin = 1'b1;
    refresh    = 1'b0;
    bj_stall   = 1'b0;
    if (deliv_count < target) begin
      $display("timeout: only %0d of %0d words under back-pressure",
               n - (target - deliv_count), n);
      timeout_count++;
    end
  endtask

  task automatic lsu_access(input logic we, input addr_t addr, input word_t wdata);
    int cycles;
    cycles     = 0;
    data_req   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_wdata = wdata;
    @(negedge clk);
    check_value("data_busy", data_busy, 1'b1);
    // second request while busy, must be dropped
    data_we    = 1'b1;
    data_addr  = 32'h0000_03FC;
    data_wdata = ~wdata;
    @(negedge clk);
    data_req = 1'b0;
    while (!data_done && cycles < 40) begin
      @(negedge clk);
      cycles++;
    end
    if (!data_done) begin
      $display("timeout: data access to %08h never finished", addr);
      timeout_count++;
    end else begin
      check_value("data_busy at done", data_busy, 1'b0);
      if (we) begin
        mirror[addr[IDX_W+1:2]] = wdata;
      end else begin
        check_value("data_rdata", data_rdata, expected_word(addr));
      end
      data_count++;
    end
  endtask

  initial begin
    seed          = 89;
    err_count     = 0;
    timeout_count = 0;
    deliv_count   = 0;
    data_count    = 0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mirror[i] = word_t'(i) * `MEM_INIT_MUL;
    end
    rst          = 1'b1;
    refresh      = 1'b0;
    id_allowin   = 1'b1;
    bj_pc        = '0;
    bj_ena       = 1'b0;
    bj_stall     = 1'b0;
    excp_jmp_ena = 1'b0;
    excp_pc      = '0;
    data_req     = 1'b0;
    data_we      = 1'b0;
    data_addr    = '0;
    data_wdata   = '0;
    exp_pc       = `PC_START;
    pend_bj      = 1'b0;
    pend_excp    = 1'b0;
    pend_bj_pc   = '0;
    pend_excp_pc = '0;
    hold_chk     = 1'b0;
    held_pc      = '0;
    held_inst    = '0;
    repeat (5) @(negedge clk);
    check_value("if_to_id_valid in reset", if_to_id_valid, 1'b0);
    check_value("data_busy in reset", data_busy, 1'b0);
    check_value("data_done in reset", data_done, 1'b0);
    rst = 1'b0;

    wait_deliveries(20);
    redirect(32'h0000_0100, 1'b0, 32'h0);
    wait_deliveries(8);
    // exception wins over a branch in the same cycle
    redirect(32'h0000_0040, 1'b1, 32'h0000_0180);
    wait_deliveries(8);
    random_backpressure(24);

    // data traffic high in memory while fetch runs low
    redirect(32'h0, 1'b0, 32'h0);
    for (int k = 0; k < 8; k++) begin
      repeat ($random(seed) & 7) @(negedge clk);
      lsu_access(1'b1, 32'h0000_0300 + k * 4, $random(seed));
    end
    for (int k = 0; k < 8; k++) begin
      repeat ($random(seed) & 7) @(negedge clk);
      lsu_access(1'b0, 32'h0000_0300 + k * 4, '0);
    end
    lsu_access(1'b0, 32'h0000_03FC, '0);
    wait_deliveries(4);

    // fetch the freshly written words
    redirect(32'h0000_0300, 1'b0, 32'h0);
    wait_deliveries(10);

    $display("summary: %0d value errors, %0d timeouts, %0d words fetched, %0d data accesses",
             err_count, timeout_count, deliv_count, data_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* rtl/fetch_sys_top.sv */
// fetch system top
// fetch stage and load/store port share one memory through the arbiter

`timescale 1ns/1ps

module fetch_sys_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             refresh,
  input  logic             id_allowin,
  input  fetch_pkg::addr_t bj_pc,
  input  logic             bj_ena,
  input  logic             bj_stall,
  input  logic             excp_jmp_ena,
  input  fetch_pkg::addr_t excp_pc,
  output logic             if_to_id_valid,
  output fetch_pkg::word_t if_inst,
  output fetch_pkg::addr_t if_pc,
  input  logic             data_req,
  input  logic             data_we,
  input  fetch_pkg::addr_t data_addr,
  input  fetch_pkg::word_t data_wdata,
  output logic             data_busy,
  output logic             data_done,
  output fetch_pkg::word_t data_rdata
);
  import fetch_pkg::*;

  // fetch requester bus
  logic  f_valid;
  logic  f_ready;
  addr_t f_addr;
  word_t f_rdata;

  // load/store requester bus
  logic  d_valid;
  logic  d_ready;
  addr_t d_addr;
  logic  d_we;
  word_t d_wdata;
  word_t d_rdata;

  // arbitrated memory bus
  logic  m_valid;
  logic  m_ready;
  addr_t m_addr;
  logic  m_we;
  word_t m_wdata;
  word_t m_rdata;

  if_stage u_if_stage (
    .clk            (clk),
    .rst            (rst),
    .refresh        (refresh),
    .id_allowin     (id_allowin),
    .bj_pc          (bj_pc),
    .bj_ena         (bj_ena),
    .bj_stall       (bj_stall),
    .excp_jmp_ena   (excp_jmp_ena),
    .excp_pc        (excp_pc),
    .if_to_id_valid (if_to_id_valid),
    .if_inst        (if_inst),
    .if_pc          (if_pc),
    .bus_valid      (f_valid),
    .bus_ready      (f_ready),
    .bus_addr       (f_addr),
    .bus_rdata      (f_rdata)
  );

  lsu_port u_lsu_port (
    .clk        (clk),
    .rst        (rst),
    .data_req   (data_req),
    .data_we    (data_we),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_busy  (data_busy),
    .data_done  (data_done),
    .data_rdata (data_rdata),
    .bus_valid  (d_valid),
    .bus_ready  (d_ready),
    .bus_addr   (d_addr),
    .bus_we     (d_we),
    .bus_wdata  (d_wdata),
    .bus_rdata  (d_rdata)
  );

  bus_arbiter u_bus_arbiter (
    .clk     (clk),
    .rst     (rst),
    .f_valid (f_valid),
    .f_ready (f_ready),
    .f_addr  (f_addr),
    .f_rdata (f_rdata),
    .d_valid (d_valid),
    .d_ready (d_ready),
    .d_addr  (d_addr),
    .d_we    (d_we),
    .d_wdata (d_wdata),
    .d_rdata (d_rdata),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_addr  (m_addr),
    .m_we    (m_we),
    .m_wdata (m_wdata),
    .m_rdata (m_rdata)
  );

  inst_mem u_inst_mem (
    .clk     (clk),
    .rst     (rst),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_addr  (m_addr),
    .m_we    (m_we),
    .m_wdata (m_wdata),
    .m_rdata (m_rdata)
  );

endmodule

/* rtl/inst_mem.sv */
// word-wide memory with wait states
// ready comes MEM_WAIT cycles after valid for one cycle, read data is
// registered, contents start from the i * MEM_INIT_MUL fill rule

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module inst_mem (
  input  logic             clk,
  input  logic             rst,
  input  logic             m_valid,
  output logic             m_ready,
  input  fetch_pkg::addr_t m_addr,
  input  logic             m_we,
  input  fetch_pkg::word_t m_wdata,
  output fetch_pkg::word_t m_rdata
);
  import fetch_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);
  localparam int CNT_W = $clog2(`MEM_WAIT + 1);

  mem_state_t       state;
  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] idx;
  logic             wait_over;
  word_t            mem [`MEM_WORDS];

  // word index, upper address bits wrap
  assign idx       = m_addr[IDX_W+1:2];
  assign m_ready   = (state == DONE);
  assign wait_over = (state == WAIT) && m_valid && (wait_cnt == CNT_W'(`MEM_WAIT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= WAIT;
      wait_cnt <= '0;
    end else begin
      case (state)
        WAIT: begin
          if (wait_over) begin
            state    <= DONE;
            wait_cnt <= '0;
          end else if (m_valid) begin
            wait_cnt <= wait_cnt + 1'b1;
          end else begin
            wait_cnt <= '0;
          end
        end
        default: state <= WAIT;
      endcase
    end
  end

  // read word lands together with ready, write on the ready cycle
  always_ff @(posedge clk) begin
    if (wait_over && !m_we) begin
      m_rdata <= mem[idx];
    end
    if ((state == DONE) && m_valid && m_we) begin
      mem[idx] <= m_wdata;
    end
  end

  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = word_t'(i) * `MEM_INIT_MUL;
    end
  end

endmodule

/* rtl/bus_arbiter.sv */
// two-requester memory bus arbiter
// data side wins when both ask from FREE, the grant is locked until
// the owner's handshake, then the bus is free again the next cycle

`timescale 1ns/1ps

module bus_arbiter (
  input  logic             clk,
  input  logic             rst,
  // fetch side
  input  logic             f_valid,
  output logic             f_ready,
  input  fetch_pkg::addr_t f_addr,
  output fetch_pkg::word_t f_rdata,
  // data side
  input  logic             d_valid,
  output logic             d_ready,
  input  fetch_pkg::addr_t d_addr,
  input  logic             d_we,
  input  fetch_pkg::word_t d_wdata,
  output fetch_pkg::word_t d_rdata,
  // memory side
  output logic             m_valid,
  input  logic             m_ready,
  output fetch_pkg::addr_t m_addr,
  output logic             m_we,
  output fetch_pkg::word_t m_wdata,
  input  fetch_pkg::word_t m_rdata
);
  import fetch_pkg::*;

  arb_state_t state;
  arb_state_t state_nxt;
  logic       own_data;
  logic       own_fetch;

  // owner this cycle, picked live in FREE
  always_comb begin
    own_data  = 1'b0;
    own_fetch = 1'b0;
    case (state)
      FREE: begin
        own_data  = d_valid;
        own_fetch = !d_valid && f_valid;
      end
      GRANT_DATA:  own_data = 1'b1;
      GRANT_FETCH: own_fetch = 1'b1;
      default:     own_data = 1'b0;
    endcase
  end

  assign d_ready = own_data && m_ready;
  assign f_ready = own_fetch && m_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      FREE: begin
        if (own_data) begin
          state_nxt = d_ready ? FREE : GRANT_DATA;
        end else if (own_fetch) begin
          state_nxt = f_ready ? FREE : GRANT_FETCH;
        end
      end
      GRANT_DATA:  if (d_ready) state_nxt = FREE;
      GRANT_FETCH: if (f_ready) state_nxt = FREE;
      default:     state_nxt = FREE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FREE;
    end else begin
      state <= state_nxt;
    end
  end

  // memory side mux, fetch never writes
  assign m_valid = own_data ? d_valid : (own_fetch && f_valid);
  assign m_addr  = own_data ? d_addr : f_addr;
  assign m_we    = own_data && d_we;
  assign m_wdata = d_wdata;

  // each side only looks at rdata after its own handshake
  assign f_rdata = m_rdata;
  assign d_rdata = m_rdata;

  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    !(f_ready && d_ready));

  // owner keeps its request up and steady until ready
  a_valid_held: assert property (@(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> m_valid && $stable(m_addr) && $stable(m_we));

endmodule

/* rtl/lsu_port.sv */
// load/store bus requester
// takes one request pulse, runs it over the shared bus and
// returns a done pulse with the read word

`timescale 1ns/1ps

module lsu_port (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_req,
  input  logic             data_we,
  input  fetch_pkg::addr_t data_addr,
  input  fetch_pkg::word_t data_wdata,
  output logic             data_busy,
  output logic             data_done,
  output fetch_pkg::word_t data_rdata,
  output logic             bus_valid,
  input  logic             bus_ready,
  output fetch_pkg::addr_t bus_addr,
  output logic             bus_we,
  output fetch_pkg::word_t bus_wdata,
  input  fetch_pkg::word_t bus_rdata
);
  import fetch_pkg::*;

  logic busy;
  logic accept;
  logic handshake;

  // requests during a pending access are dropped
  assign accept    = data_req && !busy;
  assign handshake = busy && bus_ready;

  // busy and valid share one register, both end at the handshake
  assign bus_valid = busy;
  assign data_busy = busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      data_done <= 1'b0;
    end else begin
      data_done <= handshake;
      if (accept) begin
        busy <= 1'b1;
      end else if (handshake) begin
        busy <= 1'b0;
      end
    end
  end

  // request fields held steady for the bus
  always_ff @(posedge clk) begin
    if (accept) begin
      bus_addr  <= data_addr;
      bus_we    <= data_we;
      bus_wdata <= data_wdata;
    end
    if (handshake) begin
      data_rdata <= bus_rdata;
    end
  end

  // done comes one cycle after the handshake, with the bus already idle
  a_done_after_hs: assert property (@(posedge clk) disable iff (rst)
    handshake |=> data_done && !bus_valid);

endmodule

/* rtl/if_stage.sv */
// instruction fetch stage
// picks the next pc (exception > branch/jump > pc+4), runs the
// idle/addr/return bus sequencer and holds one fetched word toward decode

`timescale 1ns/1ps
`include "fetch_cfg.svh"

module if_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             refresh,
  input  logic             id_allowin,
  input  fetch_pkg::addr_t bj_pc,
  input  logic             bj_ena,
  input  logic             bj_stall,
  input  logic             excp_jmp_ena,
  input  fetch_pkg::addr_t excp_pc,
  output logic             if_to_id_valid,
  output fetch_pkg::word_t if_inst,
  output fetch_pkg::addr_t if_pc,
  output logic             bus_valid,
  input  logic             bus_ready,
  output fetch_pkg::addr_t bus_addr,
  input  fetch_pkg::word_t bus_rdata
);
  import fetch_pkg::*;

  fetch_state_t state;
  fetch_state_t state_nxt;

  // pc of the request in flight, or of the last one issued
  addr_t fetch_pc;
  addr_t next_pc;
  word_t ret_inst;
  logic  if_valid;
  logic  handshake;
  logic  launch;
  logic  stage_allowin;
  logic  stage_load;

  // redirects only count in a cycle that launches a request
  assign next_pc = excp_jmp_ena ? excp_pc :
                   bj_ena       ? bj_pc   :
                   fetch_pc + addr_t'(4);

  assign bus_valid = (state == ADDR);
  assign bus_addr  = fetch_pc;
  assign handshake = bus_valid && bus_ready;

  // decode side register
  assign if_to_id_valid = if_valid && !refresh;
  assign stage_allowin  = !if_valid || (if_to_id_valid && id_allowin);

  // word leaves RETN only when the stage has room and no stall holds it
  assign stage_load = (state == RETN) && stage_allowin && !bj_stall;
  assign launch     = ((state == IDLE) && !bj_stall) || stage_load;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (!bj_stall) state_nxt = ADDR;
      ADDR:    if (handshake) state_nxt = RETN;
      RETN:    if (stage_load) state_nxt = ADDR;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      fetch_pc <= addr_t'(`PC_START - 32'd4);
    end else begin
      state <= state_nxt;
      if (launch) begin
        fetch_pc <= next_pc;
      end
    end
  end

  // memory may move on to the other requester, so keep our word
  always_ff @(posedge clk) begin
    if (handshake) begin
      ret_inst <= bus_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if_valid <= 1'b0;
    end else if (stage_load) begin
      if_valid <= 1'b1;
    end else if (if_to_id_valid && id_allowin) begin
      if_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_load) begin
      if_pc   <= fetch_pc;
      if_inst <= ret_inst;
    end
  end

  // a ready from the arbiter is only meant for a request in ADDR
  a_ready_needs_req: assert property (@(posedge clk) disable iff (rst)
    bus_ready |-> bus_valid);

endmodule

/* rtl/fetch_pkg.sv */
// fetch system types
// vector types for addresses and words, plus the FSM state encodings

`include "fetch_cfg.svh"

package fetch_pkg;

  // one address or pc
  typedef logic [`ADDR_W-1:0] addr_t;

  // one data word or instruction
  typedef logic [`DATA_W-1:0] word_t;

  // fetch bus sequencer
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RETN
  } fetch_state_t;

  // memory bus ownership
  typedef enum logic [1:0] {
    FREE,
    GRANT_FETCH,
    GRANT_DATA
  } arb_state_t;

  // memory wait sequencing
  typedef enum logic {
    WAIT,
    DONE
  } mem_state_t;

endpackage

/* rtl/fetch_cfg.svh */
// fetch system configuration
// widths, memory shape, wait states and the reset fetch address

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address / pc width
`define ADDR_W 32

// bus data and instruction width
`define DATA_W 32

// memory depth in words, index taken from addr[9:2]
`define MEM_WORDS 256

// cycles between first valid and ready, must be at least 1
`define MEM_WAIT 2

// first fetch address after reset
`define PC_START 32'h0000_0000

// word i holds i times this value after power-up
`define MEM_INIT_MUL 32'h9E37_79B1

`endif
